//--- src/uart_consts.svh
// constants for the bytewise 16450 model
// include in any file that needs addresses, masks, bit positions or IIR codes
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

`define UART_BASE_ADDR       32'h0000_0000   // 8-byte register window
`define UART_IER_MASK        8'h0f
`define UART_MCR_MASK        8'h1f
`define UART_DLL_RESET       8'h10
`define UART_CYCLES_PER_UNIT 7812            // 9 symbols at 115200, 100 MHz clock

// LCR and IER bit positions
`define UART_LCR_DLAB  7
`define UART_IER_ERBFI 0
`define UART_IER_ETBEI 1
`define UART_IER_ELSI  2
`define UART_IER_EDSSI 3

// MCR bit positions
`define UART_MCR_DTR  0
`define UART_MCR_RTS  1
`define UART_MCR_OUT1 2
`define UART_MCR_OUT2 3
`define UART_MCR_LOOP 4

// IIR values, bit 0 is the active-low pending flag
`define UART_IIR_NONE   8'h01
`define UART_IIR_LINE   8'h06
`define UART_IIR_RXDATA 8'h04
`define UART_IIR_THRE   8'h02
`define UART_IIR_MODEM  8'h00

`endif

//--- src/uartPkg.sv
// shared types for the UART model
// imported by every block that uses a meaningful width or the interrupt FSM
package uartPkg;

    // register and data path
    typedef logic [7:0] regByte_t;
    typedef logic [15:0] divisor_t;      // {DLM, DLL}

    // AXI-lite bus
    typedef logic [31:0] axiAddr_t;
    typedef logic [31:0] axiData_t;
    typedef logic [3:0] axiStrb_t;

    typedef logic [2:0] regAddr_t;       // byte offset in the window

    // wide enough for 7812 * 16'hffff
    typedef logic [28:0] baudCount_t;

    // interrupt sources in priority order
    typedef enum logic [2:0] {
        sIdle,
        sLineStatus,
        sRxData,
        sThrEmpty,
        sModemStatus
    } intState_t;

endpackage

//--- src/regAccessIf.sv
// decoded register accesses from the bus slave into the register file
// the slave drives the request side, the register file returns rdData
interface regAccessIf import uartPkg::*; ();

    logic     wrEn;      // one-cycle pulse
    regAddr_t wrAddr;
    axiData_t wrData;
    axiStrb_t wrStrb;

    logic     rdEn;      // one-cycle pulse
    regAddr_t rdAddr;
    axiData_t rdData;    // combinational, sampled on rdEn

    modport bus (
        output wrEn, wrAddr, wrData, wrStrb, rdEn, rdAddr,
        input  rdData
    );

    modport regs (
        input  wrEn, wrAddr, wrData, wrStrb, rdEn, rdAddr,
        output rdData
    );

endinterface

//--- src/axiLiteSlave.sv
// AXI-lite slave for the UART register window
// one outstanding write and one outstanding read, turned into access pulses
`include "uart_consts.svh"

module axiLiteSlave import uartPkg::*; (
    input  logic     clk,
    input  logic     rst,
    // write address and data
    input  axiAddr_t awaddr_i,
    input  logic     awvalid_i,
    output logic     awready_o,
    input  axiData_t wdata_i,
    input  axiStrb_t wstrb_i,
    input  logic     wvalid_i,
    output logic     wready_o,
    // write response
    output logic [1:0] bresp_o,
    output logic     bvalid_o,
    input  logic     bready_i,
    // read address and data
    input  axiAddr_t araddr_i,
    input  logic     arvalid_i,
    output logic     arready_o,
    output axiData_t rdata_o,
    output logic [1:0] rresp_o,
    output logic     rvalid_o,
    input  logic     rready_i,
    regAccessIf.bus  regBus
);

    localparam axiAddr_t baseAddr = `UART_BASE_ADDR;

    logic wrSel, rdSel;
    logic wrAccept, rdAccept;

    // out-of-window requests are left hanging
    assign wrSel = (awaddr_i[31:3] == baseAddr[31:3]);
    assign rdSel = (araddr_i[31:3] == baseAddr[31:3]);

    // no new request while a response still waits
    assign wrAccept = awvalid_i & wvalid_i & wrSel & ~bvalid_o;
    assign rdAccept = arvalid_i & rdSel & ~rvalid_o;

    assign awready_o = wrAccept;
    assign wready_o  = wrAccept;
    assign arready_o = rdAccept;

    assign regBus.wrEn   = wrAccept;
    assign regBus.wrAddr = awaddr_i[2:0];
    assign regBus.wrData = wdata_i;
    assign regBus.wrStrb = wstrb_i;
    assign regBus.rdEn   = rdAccept;
    assign regBus.rdAddr = araddr_i[2:0];

    assign bresp_o = 2'b00;   // OKAY
    assign rresp_o = 2'b00;

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid_o <= 1'b0;
            rvalid_o <= 1'b0;
        end else begin
            if (wrAccept)
                bvalid_o <= 1'b1;
            else if (bready_i)
                bvalid_o <= 1'b0;

            if (rdAccept)
                rvalid_o <= 1'b1;
            else if (rready_i)
                rvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rdAccept)
            rdata_o <= regBus.rdData;   // held until the next read
    end

endmodule

//--- src/uartRegFile.sv
// programmable registers of the 16450 model and the read data mux
// also produces the read and write side-effect pulses for the other blocks
`include "uart_consts.svh"

module uartRegFile import uartPkg::*; (
    input  logic     clk,
    input  logic     rst,
    regAccessIf.regs regBus,
    output logic     thrWrite_o,
    output regByte_t thrData_o,
    output logic     rbrRead_o,
    output logic     lsrRead_o,
    output logic     msrRead_o,
    output regByte_t ier_o,
    output regByte_t lsr_o,
    output regByte_t msr_o,
    input  regByte_t rbr_i,
    input  logic     dataReady_i,
    input  logic     overrun_i,
    input  logic     thrEmpty_i,
    input  logic     txIdle_i,
    input  regByte_t iir_i,
    output divisor_t divisor_o
);

    regByte_t ier, lcr, mcr, scr, dll, dlm;
    regByte_t rxByte;      // byte 0 of word 0 on a read
    logic     dlab, loop;
    logic     wrLow, rdLow;   // word 0 selected

    assign dlab  = lcr[`UART_LCR_DLAB];
    assign loop  = mcr[`UART_MCR_LOOP];
    assign wrLow = ~regBus.wrAddr[2];
    assign rdLow = ~regBus.rdAddr[2];

    always_ff @(posedge clk) begin
        if (rst) begin
            ier <= '0;
            lcr <= '0;
            mcr <= '0;
            scr <= '0;
            dll <= `UART_DLL_RESET;
            dlm <= '0;
        end else if (regBus.wrEn) begin
            if (wrLow) begin
                if (regBus.wrStrb[0] && dlab)
                    dll <= regBus.wrData[7:0];
                if (regBus.wrStrb[1]) begin
                    if (dlab)
                        dlm <= regBus.wrData[15:8];
                    else
                        ier <= regBus.wrData[15:8] & `UART_IER_MASK;
                end
                // lane 2 would be FCR, no FIFOs here
                if (regBus.wrStrb[3])
                    lcr <= regBus.wrData[31:24];
            end else begin
                if (regBus.wrStrb[0])
                    mcr <= regBus.wrData[7:0] & `UART_MCR_MASK;
                if (regBus.wrStrb[3])
                    scr <= regBus.wrData[31:24];
            end
        end
    end

    // THR lives in txHolding, just pass the byte on
    assign thrWrite_o = regBus.wrEn & wrLow & regBus.wrStrb[0] & ~dlab;
    assign thrData_o  = regBus.wrData[7:0];

    // TEMT, THRE, then OE and DR, error bits never set
    assign lsr_o = {1'b0, thrEmpty_i & txIdle_i, thrEmpty_i, 3'b000, overrun_i, dataReady_i};

    // DCD RI DSR CTS, deltas always zero
    assign msr_o[7] = loop ? mcr[`UART_MCR_OUT2] : 1'b0;
    assign msr_o[6] = loop ? mcr[`UART_MCR_OUT1] : 1'b0;
    assign msr_o[5] = loop ? mcr[`UART_MCR_DTR] : 1'b1;
    assign msr_o[4] = loop ? mcr[`UART_MCR_RTS] : 1'b1;
    assign msr_o[3:0] = 4'b0000;

    assign ier_o     = ier;
    assign divisor_o = {dlm, dll};

    // unaligned reads of word 0 must not pop RBR
    always_comb begin
        if (dlab)
            rxByte = dll;
        else if (regBus.rdAddr == 3'd0)
            rxByte = rbr_i;
        else
            rxByte = '0;
    end

    assign regBus.rdData = rdLow ? {lcr, iir_i, (dlab ? dlm : ier), rxByte}
                                 : {scr, msr_o, lsr_o, mcr};

    assign rbrRead_o = regBus.rdEn & rdLow & ~dlab & (regBus.rdAddr == 3'd0);
    assign msrRead_o = regBus.rdEn & ~rdLow & (regBus.rdAddr != 3'd7);
    assign lsrRead_o = regBus.rdEn & ~rdLow & (regBus.rdAddr < 3'd6);

endmodule

//--- src/rxHolding.sv
// receive buffer register, loaded by a byte strobe from the far side
// tracks data ready and overrun for LSR
module rxHolding import uartPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  regByte_t rxData_i,
    input  logic     rxValid_i,
    input  logic     rbrRead_i,
    input  logic     lsrRead_i,
    output regByte_t rbr_o,
    output logic     dataReady_o,
    output logic     overrun_o
);

    always_ff @(posedge clk) begin
        if (rst) begin
            dataReady_o <= 1'b0;
            overrun_o   <= 1'b0;
        end else begin
            if (rxValid_i) begin
                dataReady_o <= 1'b1;   // new byte wins over a read
                if (dataReady_o && !rbrRead_i)
                    overrun_o <= 1'b1; // previous byte lost
            end else if (rbrRead_i) begin
                dataReady_o <= 1'b0;
            end
            if (lsrRead_i)
                overrun_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rxValid_i)
            rbr_o <= rxData_i;
    end

endmodule

//--- src/txHolding.sv
// transmit holding register with a counter standing in for the shift time
// a byte leaves as a one-cycle strobe, then the next waits cyclesPerUnit * divisor
`include "uart_consts.svh"

module txHolding import uartPkg::*; #(
    parameter int cyclesPerUnit = `UART_CYCLES_PER_UNIT
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     thrWrite_i,
    input  regByte_t thrData_i,
    input  divisor_t divisor_i,
    output regByte_t txData_o,
    output logic     txValid_o,
    output logic     thrEmpty_o,
    output logic     txIdle_o
);

    localparam baudCount_t unitCycles = baudCount_t'(cyclesPerUnit);

    regByte_t   thr;
    logic       thrFull;
    logic       launch;
    baudCount_t baudCount;

    assign launch = thrFull & (baudCount == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            thrFull   <= 1'b0;
            baudCount <= '0;
        end else begin
            if (launch)
                thrFull <= 1'b0;
            else if (thrWrite_i)
                thrFull <= 1'b1;   // write while full is dropped

            if (launch)
                baudCount <= unitCycles * baudCount_t'(divisor_i);
            else if (baudCount != '0)
                baudCount <= baudCount - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (thrWrite_i && !thrFull)
            thr <= thrData_i;
    end

    assign txValid_o  = launch;
    assign txData_o   = thr;
    assign thrEmpty_o = ~thrFull;
    assign txIdle_o   = ~launch & (baudCount == '0);   // feeds TEMT

endmodule

//--- src/interruptCtrl.sv
// interrupt FSM with fixed priority, line status first and modem status last
// a source stays active until serviced or disabled
`include "uart_consts.svh"

module interruptCtrl import uartPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  regByte_t ier_i,
    input  regByte_t lsr_i,
    input  regByte_t msr_i,
    input  logic     rbrRead_i,
    input  logic     lsrRead_i,
    input  logic     msrRead_i,
    input  logic     thrWrite_i,
    output logic     irq_o,
    output regByte_t iir_o
);

    intState_t state, nextState;

    always_ff @(posedge clk) begin
        if (rst)
            state <= sIdle;
        else
            state <= nextState;
    end

    always_comb begin
        nextState = state;
        case (state)
            sIdle: begin
                if (ier_i[`UART_IER_ELSI] && lsr_i[1])          // OE
                    nextState = sLineStatus;
                else if (ier_i[`UART_IER_ERBFI] && lsr_i[0])    // DR
                    nextState = sRxData;
                else if (ier_i[`UART_IER_ETBEI] && lsr_i[5])    // THRE
                    nextState = sThrEmpty;
                else if (ier_i[`UART_IER_EDSSI] && (msr_i[7:4] != 4'b0000))
                    nextState = sModemStatus;
            end
            sLineStatus:
                if (lsrRead_i || !ier_i[`UART_IER_ELSI])
                    nextState = sIdle;
            sRxData:
                if (rbrRead_i || !ier_i[`UART_IER_ERBFI])
                    nextState = sIdle;
            sThrEmpty:
                if (thrWrite_i || !ier_i[`UART_IER_ETBEI])
                    nextState = sIdle;
            sModemStatus:
                if (msrRead_i || !ier_i[`UART_IER_EDSSI])
                    nextState = sIdle;
            default: nextState = sIdle;
        endcase
    end

    always_comb begin
        case (state)
            sLineStatus:  iir_o = `UART_IIR_LINE;
            sRxData:      iir_o = `UART_IIR_RXDATA;
            sThrEmpty:    iir_o = `UART_IIR_THRE;
            sModemStatus: iir_o = `UART_IIR_MODEM;
            default:      iir_o = `UART_IIR_NONE;
        endcase
    end

    assign irq_o = (state != sIdle);

endmodule

//--- src/fake16450.sv
// bytewise 16450 UART model behind an AXI-lite port, no serializer
// bytes enter on rxData_i/rxValid_i and leave on txData_o/txValid_o
`include "uart_consts.svh"

module fake16450 import uartPkg::*; #(
    parameter int cyclesPerUnit = `UART_CYCLES_PER_UNIT
) (
    input  logic       clk,
    input  logic       rst,
    input  axiAddr_t   awaddr_i,
    input  logic       awvalid_i,
    output logic       awready_o,
    input  axiData_t   wdata_i,
    input  axiStrb_t   wstrb_i,
    input  logic       wvalid_i,
    output logic       wready_o,
    output logic [1:0] bresp_o,
    output logic       bvalid_o,
    input  logic       bready_i,
    input  axiAddr_t   araddr_i,
    input  logic       arvalid_i,
    output logic       arready_o,
    output axiData_t   rdata_o,
    output logic [1:0] rresp_o,
    output logic       rvalid_o,
    input  logic       rready_i,
    input  regByte_t   rxData_i,
    input  logic       rxValid_i,
    output regByte_t   txData_o,
    output logic       txValid_o,
    output logic       irq_o
);

    regAccessIf regBus ();

    logic     thrWrite, rbrRead, lsrRead, msrRead;
    regByte_t thrData, ier, lsr, msr, rbr, iir;
    logic     dataReady, overrun, thrEmpty, txIdle;
    divisor_t divisor;

    axiLiteSlave axiSlave0 (
        .clk, .rst,
        .awaddr_i, .awvalid_i, .awready_o,
        .wdata_i, .wstrb_i, .wvalid_i, .wready_o,
        .bresp_o, .bvalid_o, .bready_i,
        .araddr_i, .arvalid_i, .arready_o,
        .rdata_o, .rresp_o, .rvalid_o, .rready_i,
        .regBus (regBus.bus)
    );

    uartRegFile regFile0 (
        .clk, .rst,
        .regBus      (regBus.regs),
        .thrWrite_o  (thrWrite),
        .thrData_o   (thrData),
        .rbrRead_o   (rbrRead),
        .lsrRead_o   (lsrRead),
        .msrRead_o   (msrRead),
        .ier_o       (ier),
        .lsr_o       (lsr),
        .msr_o       (msr),
        .rbr_i       (rbr),
        .dataReady_i (dataReady),
        .overrun_i   (overrun),
        .thrEmpty_i  (thrEmpty),
        .txIdle_i    (txIdle),
        .iir_i       (iir),
        .divisor_o   (divisor)
    );

    rxHolding rxHold0 (
        .clk, .rst, .rxData_i, .rxValid_i,
        .rbrRead_i   (rbrRead),
        .lsrRead_i   (lsrRead),
        .rbr_o       (rbr),
        .dataReady_o (dataReady),
        .overrun_o   (overrun)
    );

    txHolding #(.cyclesPerUnit(cyclesPerUnit)) txHold0 (
        .clk, .rst, .txData_o, .txValid_o,
        .thrWrite_i (thrWrite),
        .thrData_i  (thrData),
        .divisor_i  (divisor),
        .thrEmpty_o (thrEmpty),
        .txIdle_o   (txIdle)
    );

    interruptCtrl intCtrl0 (
        .clk, .rst, .irq_o,
        .ier_i      (ier),
        .lsr_i      (lsr),
        .msr_i      (msr),
        .rbrRead_i  (rbrRead),
        .lsrRead_i  (lsrRead),
        .msrRead_i  (msrRead),
        .thrWrite_i (thrWrite),
        .iir_o      (iir)
    );

endmodule

//--- tb/fake16450Tb.sv
// testbench for the bytewise 16450 model behind AXI-lite
// runs register, receive, transmit pacing and interrupt tests, then prints a summary
module fake16450Tb import uartPkg::*; ();

    localparam int busLimit = 50;   // cycles allowed per handshake

    logic       clk, rst;
    axiAddr_t   awaddr, araddr;
    axiData_t   wdata, rdata;
    axiStrb_t   wstrb;
    logic       awvalid, awready, wvalid, wready, bvalid, bready;
    logic       arvalid, arready, rvalid, rready;
    logic [1:0] bresp, rresp;
    regByte_t   rxData, txData;
    logic       rxValid, txValid, irq;

    int          errorCount = 0;
    int          checkCount = 0;
    int          testErrors = 0;
    int          testNum = 0;
    logic [31:0] rngState = 32'h1d00_7e23;

    // tx, irq and handshake monitor state
    int       cycle = 0;
    regByte_t txBytes[$];
    int       txCycles[$];
    int       irqFalls = 0;
    logic     irqPrev = 1'b0;
    int       awPulses = 0;
    int       wPulses = 0;
    int       arPulses = 0;

    fake16450 #(.cyclesPerUnit(4)) dut0 (
        .clk, .rst,
        .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready),
        .wdata_i (wdata), .wstrb_i (wstrb), .wvalid_i (wvalid), .wready_o (wready),
        .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready),
        .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
        .rdata_o (rdata), .rresp_o (rresp), .rvalid_o (rvalid), .rready_i (rready),
        .rxData_i (rxData), .rxValid_i (rxValid),
        .txData_o (txData), .txValid_o (txValid), .irq_o (irq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // sampled on the rising edge, read by the main sequence on the falling one
    always @(posedge clk) begin
        if (rst) begin
            irqPrev = 1'b0;
        end else begin
            cycle = cycle + 1;
            if (txValid) begin
                txBytes.push_back(txData);
                txCycles.push_back(cycle);
            end
            if (irqPrev && !irq)
                irqFalls = irqFalls + 1;
            irqPrev = irq;
            if (awready)
                awPulses = awPulses + 1;
            if (wready)
                wPulses = wPulses + 1;
            if (arready)
                arPulses = arPulses + 1;
        end
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic randomByte(output regByte_t b);
        rngState = nextRandom(rngState);
        b = rngState[7:0];
    endtask

    task automatic giveUp(input string what);
        $display("timeout while waiting for %s", what);
        $display("Checks failed");
        $finish;
    endtask

    task automatic checkByte(input string name, input regByte_t got, input regByte_t exp);
        checkCount++;
        assert (got === exp) else begin
            $display("** Error: %s = 0x%02h, expected 0x%02h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checkCount++;
        assert (got === exp) else begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkTrue(input bit ok, input string msg);
        checkCount++;
        assert (ok) else begin
            $display("%s", msg);
            errorCount++;
        end
    endtask

    // called on a falling edge, returns on one
    task automatic axiWrite(input logic [2:0] offset, input axiData_t data, input axiStrb_t strb);
        int n;
        int aw0;
        int w0;
        aw0     = awPulses;
        w0      = wPulses;
        awaddr  = {29'd0, offset};
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > busLimit)
                giveUp("the write response");
        end while (!bvalid);
        checkByte("bresp_o", {6'd0, bresp}, 8'h00);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (bvalid) begin
            @(negedge clk);
            n++;
            if (n > busLimit)
                giveUp("bvalid to drop");
        end
        checkTrue(awPulses == aw0 + 1, "awready_o was not high for exactly one cycle");
        checkTrue(wPulses == w0 + 1, "wready_o was not high for exactly one cycle");
    endtask

    task automatic axiRead(input logic [2:0] offset, output axiData_t data);
        int n;
        int ar0;
        ar0     = arPulses;
        araddr  = {29'd0, offset};
        arvalid = 1'b1;
        rready  = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > busLimit)
                giveUp("the read data");
        end while (!rvalid);
        data    = rdata;
        checkByte("rresp_o", {6'd0, rresp}, 8'h00);
        arvalid = 1'b0;
        n = 0;
        while (rvalid) begin
            @(negedge clk);
            n++;
            if (n > busLimit)
                giveUp("rvalid to drop");
        end
        checkTrue(arPulses == ar0 + 1, "arready_o was not high for exactly one cycle");
    endtask

    task automatic sendRx(input regByte_t b);
        rxData  = b;
        rxValid = 1'b1;
        @(negedge clk);
        rxValid = 1'b0;
    endtask

    task automatic waitIrq(input logic level);
        int n;
        n = 0;
        while (irq !== level && n < busLimit) begin
            @(negedge clk);
            n++;
        end
        checkBit("irq_o", irq, level);
    endtask

    task automatic waitIrqFall(input int base);
        int n;
        n = 0;
        while (irqFalls <= base && n < busLimit) begin
            @(negedge clk);
            n++;
        end
        checkTrue(irqFalls > base, "irq_o did not drop after the service access");
    endtask

    // polls LSR through offset 5 until THRE
    task automatic waitThre();
        axiData_t d;
        int n;
        n = 0;
        axiRead(3'd5, d);
        while (!d[13]) begin
            n++;
            if (n > 20)
                giveUp("THRE");
            axiRead(3'd5, d);
        end
    endtask

    task automatic startTest();
        testNum++;
        testErrors = errorCount;
    endtask

    task automatic finishTest(input string name);
        if (errorCount == testErrors)
            $display("test %0d %s: ok", testNum, name);
        else
            $display("test %0d %s: %0d errors", testNum, name, errorCount - testErrors);
    endtask

    initial begin
        axiData_t d;
        regByte_t b0, b1, b2, t0, t1;
        int base, gap, n, falls;

        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        rxData = '0;
        rxValid = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        startTest();
        axiRead(3'd4, d);
        checkByte("LSR", d[15:8], 8'h60);
        checkByte("MSR", d[23:16], 8'h30);
        checkByte("MCR", d[7:0], 8'h00);
        checkByte("SCR", d[31:24], 8'h00);
        axiRead(3'd0, d);
        checkByte("IIR", d[23:16], 8'h01);
        checkByte("LCR", d[31:24], 8'h00);
        checkBit("irq_o", irq, 1'b0);
        finishTest("reset state");

        startTest();
        axiWrite(3'd4, 32'ha500_0000, 4'b1000);
        axiRead(3'd4, d);
        checkByte("SCR", d[31:24], 8'ha5);
        axiWrite(3'd0, 32'h0300_0000, 4'b1000);
        axiRead(3'd0, d);
        checkByte("LCR", d[31:24], 8'h03);
        axiWrite(3'd0, 32'h0000_fa00, 4'b0010);   // upper nibble dropped
        axiRead(3'd0, d);
        checkByte("IER", d[15:8], 8'h0a);
        axiWrite(3'd0, 32'h8300_0000, 4'b1000);   // DLAB on
        axiRead(3'd0, d);
        checkByte("DLL", d[7:0], 8'h10);
        checkByte("DLM", d[15:8], 8'h00);
        axiWrite(3'd0, 32'h0000_3c5a, 4'b0011);
        axiRead(3'd0, d);
        checkByte("DLL", d[7:0], 8'h5a);
        checkByte("DLM", d[15:8], 8'h3c);
        axiWrite(3'd0, 32'h0300_0000, 4'b1000);
        axiRead(3'd0, d);
        checkByte("IER", d[15:8], 8'h0a);
        axiWrite(3'd0, 32'h0000_0000, 4'b0010);
        finishTest("register access");

        startTest();
        randomByte(b0);
        sendRx(b0);
        axiRead(3'd6, d);   // LSR without clearing OE
        checkBit("LSR.DR", d[8], 1'b1);
        axiRead(3'd0, d);
        checkByte("RBR", d[7:0], b0);
        axiRead(3'd6, d);
        checkBit("LSR.DR", d[8], 1'b0);
        randomByte(b1);
        randomByte(b2);
        sendRx(b1);
        sendRx(b2);
        axiRead(3'd6, d);
        checkBit("LSR.OE", d[9], 1'b1);
        axiRead(3'd6, d);
        checkBit("LSR.OE", d[9], 1'b1);
        axiRead(3'd5, d);   // this one clears OE
        checkBit("LSR.OE", d[9], 1'b1);
        axiRead(3'd6, d);
        checkBit("LSR.OE", d[9], 1'b0);
        axiRead(3'd0, d);
        checkByte("RBR", d[7:0], b2);
        finishTest("receive");

        startTest();
        axiWrite(3'd0, 32'h8300_0000, 4'b1000);
        axiWrite(3'd0, 32'h0000_0003, 4'b0011);   // divisor 3
        axiWrite(3'd0, 32'h0300_0000, 4'b1000);
        base = txBytes.size();
        randomByte(t0);
        randomByte(t1);
        waitThre();
        axiWrite(3'd0, {24'd0, t0}, 4'b0001);
        waitThre();
        axiWrite(3'd0, {24'd0, t1}, 4'b0001);
        n = 0;
        while (txBytes.size() < base + 2) begin
            if (n == 200)
                giveUp("the second transmitted byte");
            n++;
            @(negedge clk);
        end
        axiRead(3'd5, d);   // pacer still counting
        checkBit("LSR.TEMT", d[14], 1'b0);
        checkByte("txData_o", txBytes[base], t0);
        checkByte("txData_o", txBytes[base + 1], t1);
        gap = txCycles[base + 1] - txCycles[base];
        checkTrue(gap >= 12, $sformatf("second tx byte only %0d cycles after the first", gap));
        n = 0;
        while (cycle < txCycles[base + 1] + 14 && n < busLimit) begin
            @(negedge clk);
            n++;
        end
        axiRead(3'd5, d);
        checkBit("LSR.TEMT", d[14], 1'b1);
        checkBit("LSR.THRE", d[13], 1'b1);
        finishTest("transmit pacing");

        startTest();
        axiWrite(3'd0, 32'h0000_0100, 4'b0010);   // ERBFI
        randomByte(b0);
        sendRx(b0);
        waitIrq(1'b1);
        axiRead(3'd1, d);   // offset 1 leaves RBR alone
        checkByte("IIR", d[23:16], 8'h04);
        axiRead(3'd0, d);
        checkByte("RBR", d[7:0], b0);
        waitIrq(1'b0);
        axiWrite(3'd0, 32'h0000_0200, 4'b0010);   // ETBEI
        waitIrq(1'b1);
        axiRead(3'd1, d);
        checkByte("IIR", d[23:16], 8'h02);
        axiRead(3'd1, d);
        checkByte("IIR", d[23:16], 8'h02);
        falls = irqFalls;
        randomByte(t0);
        axiWrite(3'd0, {24'd0, t0}, 4'b0001);
        waitIrqFall(falls);
        axiWrite(3'd4, 32'h0000_0018, 4'b0001);   // loop + OUT2
        axiWrite(3'd0, 32'h0000_0800, 4'b0010);   // EDSSI
        waitIrq(1'b1);
        axiRead(3'd1, d);
        checkByte("IIR", d[23:16], 8'h00);
        checkBit("irq_o", irq, 1'b1);
        falls = irqFalls;
        axiRead(3'd4, d);
        checkByte("MSR", d[23:16], 8'h80);
        waitIrqFall(falls);
        axiWrite(3'd0, 32'h0000_0000, 4'b0010);
        axiWrite(3'd4, 32'h0000_0000, 4'b0001);
        axiWrite(3'd0, 32'h0000_0400, 4'b0010);   // ELSI
        randomByte(b1);
        randomByte(b2);
        sendRx(b1);
        sendRx(b2);
        waitIrq(1'b1);
        axiRead(3'd1, d);
        checkByte("IIR", d[23:16], 8'h06);
        axiRead(3'd5, d);
        waitIrq(1'b0);
        axiRead(3'd0, d);
        axiWrite(3'd0, 32'h0000_0000, 4'b0010);
        finishTest("interrupts");

        $display("%0d tests, %0d checks, %0d errors", testNum, checkCount, errorCount);
        if (errorCount == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+src
src/uartPkg.sv
src/regAccessIf.sv
src/axiLiteSlave.sv
src/uartRegFile.sv
src/rxHolding.sv
src/txHolding.sv
src/interruptCtrl.sv
src/fake16450.sv
tb/fake16450Tb.sv

//--- Makefile
SRCS := $(wildcard src/*.sv src/*.svh tb/*.sv)

.PHONY: all run clean

all: obj_dir/Vfake16450Tb

obj_dir/Vfake16450Tb: verilog.f $(SRCS)
	verilator --binary --assert --top-module fake16450Tb -f verilog.f

run: obj_dir/Vfake16450Tb
	@out="$$(./obj_dir/Vfake16450Tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
